/* common/l2c_defs.svh */
`ifndef L2C_DEFS_SVH
`define L2C_DEFS_SVH

// address split: tag | index | offset
`define L2C_ADDR_W    32
`define L2C_WORD_W    32
`define L2C_OFFSET_W  4    // 16-byte lines
`define L2C_INDEX_W   4
`define L2C_TAG_W     24

// line geometry, also the memory bus width
`define L2C_LINE_W    128
`define L2C_WORDS     4

// organisation
`define L2C_SETS      16
`define L2C_WAYS      4
`define L2C_WAY_W     2

`endif

/* common/l2c_pkg.sv */
`include "l2c_defs.svh"

package l2c_pkg;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_OP,
        ST_CHECK_DIRTY,
        ST_WRITEBACK,
        ST_REFILL_REQ,
        ST_REFILL_WAIT
    } l2c_state_e;

    // maintenance ops
    typedef enum logic [1:0] {
        OP_INDEX_INV,
        OP_INDEX_WB_INV,
        OP_HIT_WB_INV
    } l2c_op_e;

    typedef logic [`L2C_ADDR_W-1:0]   addr_t;
    typedef logic [`L2C_WORD_W-1:0]   word_t;
    typedef logic [`L2C_LINE_W-1:0]   line_t;
    typedef logic [`L2C_TAG_W-1:0]    tag_t;
    typedef logic [`L2C_INDEX_W-1:0]  index_t;
    typedef logic [`L2C_OFFSET_W-1:0] offset_t;
    typedef logic [`L2C_WAY_W-1:0]    way_t;
    typedef logic [`L2C_WAYS-1:0]     way_mask_t;

endpackage

/* design/l2c_array/l2c_tag_array.sv */
`timescale 1ns/1ns
`include "l2c_defs.svh"

module l2c_tag_array import l2c_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  index_t    index_i,
    input  tag_t      tag_i,
    input  way_t      way_i,
    input  logic      fill_i,
    input  logic      fill_dirty_i,
    input  logic      set_dirty_i,
    input  logic      inv_i,
    output way_mask_t hit_o,
    output logic      dirty_o,
    output tag_t      victim_tag_o
);

    tag_t      tag_mem [`L2C_SETS][`L2C_WAYS];
    way_mask_t valid_q [`L2C_SETS];
    way_mask_t dirty_q [`L2C_SETS];

    ////////////////////////////////////////
    // lookup

    always_comb begin
        for (int w = 0; w < `L2C_WAYS; w++) begin
            hit_o[w] = valid_q[index_i][w] && (tag_mem[index_i][w] == tag_i);
        end
    end

    assign dirty_o      = dirty_q[index_i][way_i];
    assign victim_tag_o = tag_mem[index_i][way_i];   // for writeback address

    ////////////////////////////////////////
    // update

    always_ff @(posedge clk) begin
        if (fill_i) tag_mem[index_i][way_i] <= tag_i;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < `L2C_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (fill_i) begin
            valid_q[index_i][way_i] <= 1'b1;
            dirty_q[index_i][way_i] <= fill_dirty_i;
        end else if (inv_i) begin
            valid_q[index_i][way_i] <= 1'b0;
            dirty_q[index_i][way_i] <= 1'b0;
        end else if (set_dirty_i) begin
            dirty_q[index_i][way_i] <= 1'b1;
        end
    end

endmodule

/* design/l2c_array/l2c_data_array.sv */
`timescale 1ns/1ns
`include "l2c_defs.svh"

module l2c_data_array import l2c_pkg::*; (
    input  logic   clk,
    input  index_t index_i,
    input  way_t   way_i,
    input  logic   we_i,
    input  line_t  wline_i,
    output line_t  rline_o
);

    line_t line_mem [`L2C_SETS][`L2C_WAYS];

    // async read, the controller samples in the same cycle
    assign rline_o = line_mem[index_i][way_i];

    always_ff @(posedge clk) begin
        if (we_i) begin
            line_mem[index_i][way_i] <= wline_i;
        end
    end

endmodule

/* design/l2c_plru.sv */
`timescale 1ns/1ns
`include "l2c_defs.svh"

module l2c_plru import l2c_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  index_t index_i,
    input  logic   touch_i,
    input  way_t   touch_way_i,
    output way_t   victim_o
);

    // [0] root, [1] ways 0/1, [2] ways 2/3
    logic [2:0] tree_q [`L2C_SETS];
    logic [2:0] cur;

    assign cur = tree_q[index_i];

    // bits point toward the older half
    assign victim_o = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < `L2C_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch_i) begin
            tree_q[index_i][0] <= ~touch_way_i[1];
            if (touch_way_i[1]) tree_q[index_i][2] <= ~touch_way_i[0];
            else tree_q[index_i][1] <= ~touch_way_i[0];
        end
    end

endmodule

/* design/l2c_ctrl/l2c_datapath.sv */
`timescale 1ns/1ns
`include "l2c_defs.svh"

module l2c_datapath import l2c_pkg::*; (
    input  line_t   rline_i,
    input  line_t   mem_rdata_i,
    input  offset_t offset_i,
    input  word_t   wdata_i,
    input  logic    refill_sel_i,
    input  logic    merge_i,
    output line_t   wline_o,
    output word_t   rdata_o
);

    line_t base_line;
    logic [`L2C_OFFSET_W-3:0] word_sel;   // word inside the line

    assign word_sel  = offset_i[`L2C_OFFSET_W-1:2];
    assign base_line = refill_sel_i ? mem_rdata_i : rline_i;

    assign rdata_o = base_line[word_sel * `L2C_WORD_W +: `L2C_WORD_W];

    // replace the addressed word on a write
    always_comb begin
        wline_o = base_line;
        if (merge_i) begin
            wline_o[word_sel * `L2C_WORD_W +: `L2C_WORD_W] = wdata_i;
        end
    end

endmodule

/* design/l2c_ctrl/l2c_ctrl.sv */
`timescale 1ns/1ns
`include "l2c_defs.svh"

module l2c_ctrl import l2c_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      req_i,
    input  logic      we_i,
    input  addr_t     addr_i,
    input  word_t     wdata_i,
    input  logic      op_i,
    input  l2c_op_e   op_code_i,
    input  addr_t     op_addr_i,
    input  logic      mem_addr_ok_r_i,
    input  logic      mem_addr_ok_w_i,
    input  logic      mem_data_ok_i,
    input  way_mask_t hit_i,
    input  logic      dirty_i,
    input  tag_t      victim_tag_i,
    input  way_t      plru_victim_i,
    output logic      addr_ok_o,
    output logic      data_ok_o,
    output logic      op_ack_o,
    output logic      mem_req_r_o,
    output logic      mem_req_w_o,
    output logic      mem_rdy_o,
    output addr_t     mem_addr_o,
    output index_t    index_o,
    output tag_t      tag_o,
    output offset_t   offset_o,
    output word_t     wdata_o,
    output way_t      way_o,
    output logic      fill_o,
    output logic      fill_dirty_o,
    output logic      set_dirty_o,
    output logic      inv_o,
    output logic      data_we_o,
    output logic      refill_sel_o,
    output logic      merge_o,
    output logic      touch_o
);

    l2c_state_e state, next_state;

    // request buffer
    logic    buf_op;
    l2c_op_e buf_op_code;
    logic    buf_we;
    addr_t   buf_addr;
    word_t   buf_wdata;
    way_t    buf_way;        // way being worked on after lookup / op

    logic    hit;
    way_t    hit_way;

    function automatic way_t onehot_to_way(way_mask_t m);
        way_t w;
        w = '0;
        for (int i = `L2C_WAYS - 1; i >= 0; i--) begin
            if (m[i]) w = way_t'(i);   // lowest set way wins
        end
        return w;
    endfunction

    assign hit     = |hit_i;
    assign hit_way = onehot_to_way(hit_i);

    assign offset_o = buf_addr[`L2C_OFFSET_W-1:0];
    assign index_o  = buf_addr[`L2C_OFFSET_W +: `L2C_INDEX_W];
    assign tag_o    = buf_addr[`L2C_ADDR_W-1 -: `L2C_TAG_W];
    assign wdata_o  = buf_wdata;

    // victim line address while writing back, else the buffered line
    assign mem_addr_o = (state == ST_WRITEBACK) ?
                        {victim_tag_i, index_o, {`L2C_OFFSET_W{1'b0}}} :
                        {tag_o, index_o, {`L2C_OFFSET_W{1'b0}}};

    ////////////////////////////////////////
    // state register and buffer

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state  <= ST_IDLE;
            buf_op <= 1'b0;
        end else begin
            state <= next_state;
            if (state == ST_IDLE) begin
                if (op_i) buf_op <= 1'b1;
                else if (req_i) buf_op <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            if (op_i) begin
                buf_addr    <= op_addr_i;
                buf_op_code <= op_code_i;
            end else if (req_i) begin
                buf_addr  <= addr_i;
                buf_we    <= we_i;
                buf_wdata <= wdata_i;
            end
        end
        if (state == ST_LOOKUP && !hit) buf_way <= plru_victim_i;
        else if (state == ST_OP) buf_way <= way_o;
    end

    ////////////////////////////////////////
    // next state and strobes

    always_comb begin
        next_state   = state;
        addr_ok_o    = 1'b0;
        data_ok_o    = 1'b0;
        op_ack_o     = 1'b0;
        mem_req_r_o  = 1'b0;
        mem_req_w_o  = 1'b0;
        mem_rdy_o    = 1'b0;
        way_o        = buf_way;
        fill_o       = 1'b0;
        fill_dirty_o = 1'b0;
        set_dirty_o  = 1'b0;
        inv_o        = 1'b0;
        data_we_o    = 1'b0;
        refill_sel_o = 1'b0;
        merge_o      = 1'b0;
        touch_o      = 1'b0;
        case (state)
            ST_IDLE: begin
                if (op_i) begin
                    next_state = ST_OP;     // ops go first
                end else if (req_i) begin
                    addr_ok_o  = 1'b1;
                    next_state = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                way_o = hit_way;
                if (hit) begin
                    data_ok_o   = 1'b1;
                    touch_o     = 1'b1;
                    data_we_o   = buf_we;
                    merge_o     = buf_we;
                    set_dirty_o = buf_we;
                    next_state  = ST_IDLE;
                end else begin
                    next_state = ST_CHECK_DIRTY;
                end
            end
            ST_OP: begin
                op_ack_o = 1'b1;
                way_o    = (buf_op_code == OP_HIT_WB_INV) ? hit_way :
                           way_t'(buf_addr[`L2C_WAY_W-1:0]);
                case (buf_op_code)
                    OP_INDEX_INV: begin
                        inv_o      = 1'b1;
                        next_state = ST_IDLE;
                    end
                    OP_INDEX_WB_INV: next_state = ST_CHECK_DIRTY;
                    OP_HIT_WB_INV:   next_state = hit ? ST_CHECK_DIRTY : ST_IDLE;
                    default:         next_state = ST_IDLE;
                endcase
            end
            ST_CHECK_DIRTY: begin
                if (dirty_i) begin
                    next_state = ST_WRITEBACK;
                end else if (buf_op) begin
                    inv_o      = 1'b1;     // clean line, just drop it
                    next_state = ST_IDLE;
                end else begin
                    next_state = ST_REFILL_REQ;
                end
            end
            ST_WRITEBACK: begin
                mem_req_w_o = 1'b1;
                if (mem_addr_ok_w_i) begin
                    inv_o      = buf_op;
                    next_state = buf_op ? ST_IDLE : ST_REFILL_REQ;
                end
            end
            ST_REFILL_REQ: begin
                mem_req_r_o = 1'b1;
                if (mem_addr_ok_r_i) next_state = ST_REFILL_WAIT;
            end
            ST_REFILL_WAIT: begin
                mem_rdy_o = 1'b1;
                if (mem_data_ok_i) begin
                    // write-allocate merge in the fill cycle
                    refill_sel_o = 1'b1;
                    data_we_o    = 1'b1;
                    fill_o       = 1'b1;
                    fill_dirty_o = buf_we;
                    merge_o      = buf_we;
                    touch_o      = 1'b1;
                    data_ok_o    = 1'b1;
                    next_state   = ST_IDLE;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

endmodule

/* design/l2c_top.sv */
`timescale 1ns/1ns

module l2c_top import l2c_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    // upstream requester
    input  logic    req_i,
    input  logic    we_i,
    input  addr_t   addr_i,
    input  word_t   wdata_i,
    output logic    addr_ok_o,
    output logic    data_ok_o,
    output word_t   rdata_o,
    // maintenance port
    input  logic    op_i,
    input  l2c_op_e op_code_i,
    input  addr_t   op_addr_i,
    output logic    op_ack_o,
    // memory side
    output logic    mem_req_r_o,
    output logic    mem_req_w_o,
    output logic    mem_rdy_o,
    output addr_t   mem_addr_o,
    output line_t   mem_wdata_o,
    input  logic    mem_addr_ok_r_i,
    input  logic    mem_addr_ok_w_i,
    input  logic    mem_data_ok_i,
    input  line_t   mem_rdata_i
);

    index_t    index;
    tag_t      tag;
    offset_t   offset;
    word_t     ctrl_wdata;
    way_t      way;
    logic      fill, fill_dirty, set_dirty, inv;
    logic      data_we, refill_sel, merge, touch;
    way_mask_t hit;
    logic      dirty;
    tag_t      victim_tag;
    way_t      plru_victim;
    line_t     rline, wline;

    ////////////////////////////////////////
    // control

    l2c_ctrl l2c_ctrl_inst (
        .clk             (clk),
        .rstn            (rstn),
        .req_i           (req_i),
        .we_i            (we_i),
        .addr_i          (addr_i),
        .wdata_i         (wdata_i),
        .op_i            (op_i),
        .op_code_i       (op_code_i),
        .op_addr_i       (op_addr_i),
        .mem_addr_ok_r_i (mem_addr_ok_r_i),
        .mem_addr_ok_w_i (mem_addr_ok_w_i),
        .mem_data_ok_i   (mem_data_ok_i),
        .hit_i           (hit),
        .dirty_i         (dirty),
        .victim_tag_i    (victim_tag),
        .plru_victim_i   (plru_victim),
        .addr_ok_o       (addr_ok_o),
        .data_ok_o       (data_ok_o),
        .op_ack_o        (op_ack_o),
        .mem_req_r_o     (mem_req_r_o),
        .mem_req_w_o     (mem_req_w_o),
        .mem_rdy_o       (mem_rdy_o),
        .mem_addr_o      (mem_addr_o),
        .index_o         (index),
        .tag_o           (tag),
        .offset_o        (offset),
        .wdata_o         (ctrl_wdata),
        .way_o           (way),
        .fill_o          (fill),
        .fill_dirty_o    (fill_dirty),
        .set_dirty_o     (set_dirty),
        .inv_o           (inv),
        .data_we_o       (data_we),
        .refill_sel_o    (refill_sel),
        .merge_o         (merge),
        .touch_o         (touch)
    );

    ////////////////////////////////////////
    // storage and datapath

    l2c_tag_array l2c_tag_array_inst (
        .clk          (clk),
        .rstn         (rstn),
        .index_i      (index),
        .tag_i        (tag),
        .way_i        (way),
        .fill_i       (fill),
        .fill_dirty_i (fill_dirty),
        .set_dirty_i  (set_dirty),
        .inv_i        (inv),
        .hit_o        (hit),
        .dirty_o      (dirty),
        .victim_tag_o (victim_tag)
    );

    l2c_data_array l2c_data_array_inst (
        .clk     (clk),
        .index_i (index),
        .way_i   (way),
        .we_i    (data_we),
        .wline_i (wline),
        .rline_o (rline)
    );

    l2c_plru l2c_plru_inst (
        .clk         (clk),
        .rstn        (rstn),
        .index_i     (index),
        .touch_i     (touch),
        .touch_way_i (way),
        .victim_o    (plru_victim)
    );

    l2c_datapath l2c_datapath_inst (
        .rline_i      (rline),
        .mem_rdata_i  (mem_rdata_i),
        .offset_i     (offset),
        .wdata_i      (ctrl_wdata),
        .refill_sel_i (refill_sel),
        .merge_i      (merge),
        .wline_o      (wline),
        .rdata_o      (rdata_o)
    );

    assign mem_wdata_o = rline;   // victim line during writeback

endmodule

/* verification/l2c_mem_model.sv */
`timescale 1ns/1ns

module l2c_mem_model import l2c_pkg::*; #(
    parameter int MAX_DLY = 5
) (
    input  logic  clk,
    input  logic  rstn,
    input  logic  mem_req_r_i,
    input  logic  mem_req_w_i,
    input  logic  mem_rdy_i,
    input  addr_t mem_addr_i,
    input  line_t mem_wdata_i,
    output logic  mem_addr_ok_r_o,
    output logic  mem_addr_ok_w_o,
    output logic  mem_data_ok_o,
    output line_t mem_rdata_o
);

    localparam int LINES = 64;

    line_t mem [LINES];
    logic  filled;
    int    wr_count;        // write log
    addr_t last_wr_addr;
    line_t last_wr_line;

    int    dly_w, dly_r, dly_d;
    logic  rd_pending;
    addr_t rd_addr;

    // window slot from tag bits [11:8] and set bits [5:4]
    function automatic int slot_of(addr_t a);
        return {a[11:8], a[5:4]};
    endfunction

    initial begin
        mem_addr_ok_r_o = 1'b0;
        mem_addr_ok_w_o = 1'b0;
        mem_data_ok_o   = 1'b0;
        mem_rdata_o     = '0;
        filled          = 1'b0;
        wr_count        = 0;
        rd_pending      = 1'b0;
    end

    always @(posedge clk) begin : respond
        logic ok_w, ok_r, ok_d;
        ok_w = 1'b0;
        ok_r = 1'b0;
        ok_d = 1'b0;
        if (!rstn) begin
            if (!filled) begin
                for (int s = 0; s < LINES; s++) begin
                    mem[s] = {$urandom, $urandom, $urandom, $urandom};
                end
                filled = 1'b1;
            end
            rd_pending = 1'b0;
            dly_w      = $urandom_range(MAX_DLY, 0);
            dly_r      = $urandom_range(MAX_DLY, 0);
        end else begin
            if (mem_addr_ok_w_o && mem_req_w_i) begin   // write lands on the grant
                mem[slot_of(mem_addr_i)] = mem_wdata_i;
                wr_count++;
                last_wr_addr = mem_addr_i;
                last_wr_line = mem_wdata_i;
                dly_w        = $urandom_range(MAX_DLY, 0);
            end else if (mem_req_w_i) begin
                if (dly_w == 0) ok_w = 1'b1;
                else dly_w--;
            end
            if (mem_addr_ok_r_o && mem_req_r_i) begin
                rd_pending = 1'b1;
                rd_addr    = mem_addr_i;
                dly_r      = $urandom_range(MAX_DLY, 0);
                dly_d      = $urandom_range(MAX_DLY, 0);
            end else if (mem_req_r_i) begin
                if (dly_r == 0) ok_r = 1'b1;
                else dly_r--;
            end
            if (mem_data_ok_o && mem_rdy_i) begin
                rd_pending = 1'b0;
            end else if (rd_pending && mem_rdy_i) begin
                if (dly_d == 0) ok_d = 1'b1;
                else dly_d--;
            end
        end
        #1;
        mem_addr_ok_w_o = ok_w;
        mem_addr_ok_r_o = ok_r;
        mem_data_ok_o   = ok_d;
        mem_rdata_o     = ok_d ? mem[slot_of(rd_addr)] : '0;
    end

endmodule

/* verification/l2c_tb.sv */
`timescale 1ns/1ns
`include "l2c_defs.svh"

module l2c_tb import l2c_pkg::*; ();

    localparam int          CLK_PERIOD = 8;
    localparam int unsigned SEED       = 32'h9dea6b92;
    localparam int          N_RAND     = 400;
    localparam int          N_WORDS    = 256;   // 64 lines of 4 words
    localparam int          MAX_DLY    = 5;
    // lookup plus a writeback and a refill of up to MAX_DLY + 2 each
    localparam int          TXN_CYCLES = 2 + 2 * (MAX_DLY + 2);
    localparam int          N_TXN      = N_RAND + 150;
    localparam int          WATCHDOG   = (N_TXN * TXN_CYCLES + 1000) * CLK_PERIOD;

    logic    clk, rstn;
    logic    req, we, op;
    addr_t   addr, op_addr, mem_addr;
    word_t   wdata, rdata;
    l2c_op_e op_code;
    logic    addr_ok, data_ok, op_ack;
    logic    mem_req_r, mem_req_w, mem_rdy;
    logic    mem_addr_ok_r, mem_addr_ok_w, mem_data_ok;
    line_t   mem_wdata, mem_rdata;

    word_t   ref_mem [N_WORDS];   // latest value per word
    word_t   mem_img [N_WORDS];   // expected memory contents
    int      errors = 0;
    int      checks = 0;

    l2c_top l2c_top_inst (
        .clk (clk), .rstn (rstn),
        .req_i (req), .we_i (we), .addr_i (addr), .wdata_i (wdata),
        .addr_ok_o (addr_ok), .data_ok_o (data_ok), .rdata_o (rdata),
        .op_i (op), .op_code_i (op_code), .op_addr_i (op_addr), .op_ack_o (op_ack),
        .mem_req_r_o (mem_req_r), .mem_req_w_o (mem_req_w), .mem_rdy_o (mem_rdy),
        .mem_addr_o (mem_addr), .mem_wdata_o (mem_wdata),
        .mem_addr_ok_r_i (mem_addr_ok_r), .mem_addr_ok_w_i (mem_addr_ok_w),
        .mem_data_ok_i (mem_data_ok), .mem_rdata_i (mem_rdata)
    );

    l2c_mem_model #(.MAX_DLY (MAX_DLY)) l2c_mem_model_inst (
        .clk (clk), .rstn (rstn),
        .mem_req_r_i (mem_req_r), .mem_req_w_i (mem_req_w), .mem_rdy_i (mem_rdy),
        .mem_addr_i (mem_addr), .mem_wdata_i (mem_wdata),
        .mem_addr_ok_r_o (mem_addr_ok_r), .mem_addr_ok_w_o (mem_addr_ok_w),
        .mem_data_ok_o (mem_data_ok), .mem_rdata_o (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG);
        $display("timeout, the tests did not finish within %0d ns", WATCHDOG);
        $display("Testbench failed");
        $finish;
    end

    ////////////////////////////////////////
    // helpers

    // word number to address with tag in [11:8], set in [5:4], word in [3:2]
    function automatic addr_t addr_of(int unsigned n);
        return addr_t'({n[7:4], 2'b00, n[3:2], n[1:0], 2'b00});
    endfunction

    function automatic int unsigned line_of(addr_t a);
        return {a[11:8], a[5:4]};
    endfunction

    task automatic check_word(input string name, input addr_t a, input word_t got,
                              input word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s at %h = %h, expected %h", name, a, got, exp);
            errors++;
        end
    endtask

    // runs from one rising edge to the edge that shows data_ok
    task automatic access(input logic wr, input int unsigned n, input word_t d,
                          output word_t rd, output int lat);
        #1;
        req   = 1'b1;
        we    = wr;
        addr  = addr_of(n);
        wdata = d;
        do begin
            @(posedge clk);
        end while (!addr_ok);
        #1 req = 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!data_ok);
        rd = rdata;
        if (wr) ref_mem[n] = d;
    endtask

    task automatic read_check(input int unsigned n, output int lat);
        word_t rd;
        access(1'b0, n, '0, rd, lat);
        check_word("rdata_o", addr_of(n), rd, ref_mem[n]);
    endtask

    task automatic write_word(input int unsigned n, input word_t d);
        word_t rd;
        int    lat;
        access(1'b1, n, d, rd, lat);
    endtask

    task automatic run_op(input l2c_op_e code, input addr_t a);
        #1;
        op      = 1'b1;
        op_code = code;
        op_addr = a;
        do begin
            @(posedge clk);
        end while (!op_ack);
        #1 op = 1'b0;
        @(posedge clk);
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) $display("%-22s ok", name);
        else $display("%-22s FAIL, %0d errors", name, errors - err_before);
    endtask

    // a written back line must carry the latest words
    always @(posedge clk) begin : wb_monitor
        int unsigned s;
        if (rstn && mem_req_w && mem_addr_ok_w) begin
            s = line_of(mem_addr);
            for (int w = 0; w < `L2C_WORDS; w++) begin
                check_word("mem_wdata_o", mem_addr + 4 * w, mem_wdata[32 * w +: 32],
                           ref_mem[4 * s + w]);
                mem_img[4 * s + w] = ref_mem[4 * s + w];
            end
        end
    end

    ////////////////////////////////////////
    // tests

    initial begin
        int unsigned n, base;
        int          lat, err0, wb0;
        word_t       d, old;
        addr_t       a;
        void'($urandom(SEED));
        rstn    = 1'b0;
        req     = 1'b0;
        we      = 1'b0;
        addr    = '0;
        wdata   = '0;
        op      = 1'b0;
        op_code = OP_INDEX_INV;
        op_addr = '0;
        repeat (5) @(posedge clk);
        #1 rstn = 1'b1;
        @(posedge clk);

        err0 = errors;
        checks++;
        assert ({addr_ok, data_ok, op_ack, mem_req_r, mem_req_w, mem_rdy} === 6'b0) else begin
            $display("control outputs are not all low after reset");
            errors++;
        end
        for (int i = 0; i < N_WORDS; i++) begin
            ref_mem[i] = l2c_mem_model_inst.mem[i / 4][32 * (i % 4) +: 32];
            mem_img[i] = ref_mem[i];
        end
        read_check($urandom_range(N_WORDS - 1, 0), lat);
        report_test("reset state", err0);

        err0 = errors;
        for (int i = 0; i < N_RAND; i++) begin
            n = $urandom_range(N_WORDS - 1, 0);
            if ($urandom_range(1, 0)) write_word(n, $urandom);
            else read_check(n, lat);
        end
        report_test("random access", err0);

        err0 = errors;
        for (int i = 0; i < 8; i++) begin
            n = $urandom_range(N_WORDS - 1, 0);
            read_check(n, lat);
            read_check(n ^ 1, lat);   // other word in the same line
            checks++;
            assert (lat == 1) else begin
                $display("read hit at %h took %0d cycles instead of 1", addr_of(n ^ 1), lat);
                errors++;
            end
        end
        report_test("hit timing", err0);

        // five tags into one four-way set
        err0 = errors;
        wb0  = l2c_mem_model_inst.wr_count;
        base = $urandom_range(3, 0) * 4;
        for (int t = 0; t < 5; t++) write_word(t * 16 + base + t % 4, $urandom);
        checks++;
        assert (l2c_mem_model_inst.wr_count > wb0) else begin
            $display("no dirty line was written back during the eviction test");
            errors++;
        end
        for (int t = 0; t < 5; t++) read_check(t * 16 + base + t % 4, lat);
        report_test("dirty eviction", err0);

        err0 = errors;
        for (int s = 0; s < `L2C_SETS; s++) begin
            for (int w = 0; w < `L2C_WAYS; w++) begin
                run_op(OP_INDEX_WB_INV, addr_t'({s[3:0], 2'b00, w[1:0]}));
            end
        end
        read_check(0, lat);   // held off until the last writeback is done
        for (int i = 0; i < N_WORDS; i++) begin
            check_word("mem", addr_of(i), l2c_mem_model_inst.mem[i / 4][32 * (i % 4) +: 32],
                       ref_mem[i]);
        end
        report_test("index wb-inv sweep", err0);

        err0 = errors;
        n    = $urandom_range(N_WORDS - 1, 0);
        a    = addr_of(n);
        old  = ref_mem[n];
        write_word(n, ~old);
        for (int w = 0; w < `L2C_WAYS; w++) begin
            run_op(OP_INDEX_INV, addr_t'({a[7:4], 2'b00, w[1:0]}));
        end
        for (int i = 0; i < N_WORDS; i++) begin
            if (i[3:2] == n[3:2]) ref_mem[i] = mem_img[i];   // dirty data dropped
        end
        access(1'b0, n, '0, d, lat);
        check_word("rdata_o", a, d, old);
        report_test("index invalidate", err0);

        err0 = errors;
        n    = $urandom_range(N_WORDS - 1, 0);
        d    = $urandom;
        write_word(n, d);
        wb0  = l2c_mem_model_inst.wr_count;
        run_op(OP_HIT_WB_INV, addr_of(n));
        read_check(n, lat);
        checks++;
        assert (l2c_mem_model_inst.wr_count == wb0 + 1) else begin
            $display("hit wb-inv gave %0d line writes instead of 1",
                     l2c_mem_model_inst.wr_count - wb0);
            errors++;
        end
        check_word("mem_addr_o", addr_of(n), l2c_mem_model_inst.last_wr_addr,
                   addr_of(n) & ~32'hf);
        check_word("mem_wdata_o", addr_of(n),
                   l2c_mem_model_inst.last_wr_line[32 * (n % 4) +: 32], d);
        report_test("hit wb-inv", err0);

        $display("checks: %0d, errors: %0d, line writes: %0d",
                 checks, errors, l2c_mem_model_inst.wr_count);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+common
common/l2c_pkg.sv
design/l2c_array/l2c_tag_array.sv
design/l2c_array/l2c_data_array.sv
design/l2c_plru.sv
design/l2c_ctrl/l2c_datapath.sv
design/l2c_ctrl/l2c_ctrl.sv
design/l2c_top.sv
verification/l2c_mem_model.sv
verification/l2c_tb.sv

/* Bender.yml */
package:
  name: l2c

sources:
  - include_dirs:
      - common
    files:
      - common/l2c_pkg.sv
      - design/l2c_array/l2c_tag_array.sv
      - design/l2c_array/l2c_data_array.sv
      - design/l2c_plru.sv
      - design/l2c_ctrl/l2c_datapath.sv
      - design/l2c_ctrl/l2c_ctrl.sv
      - design/l2c_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verification/l2c_mem_model.sv
      - verification/l2c_tb.sv
